/* include/ooo_defs.svh */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// datapath width
`define OOO_XLEN 32

// architectural registers and their index width
`define OOO_NREGS 32
`define OOO_REG_W 5

// reorder buffer size, tag is its index
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W 3

// entries per reservation station
`define OOO_RS_DEPTH 4

// multiplier pipeline stages
`define OOO_MUL_LATENCY 3

`endif

/* source/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // opcodes seen by rename, stations and units
    // op_li passes its immediate through on src1
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_li,
        op_mul
    } fu_op_t;

    // reorder buffer entry life cycle
    // stations reuse empty/busy for slot tracking
    typedef enum logic [1:0] {
        st_empty,
        st_busy,
        st_done
    } ent_state_t;

endpackage

`default_nettype wire

/* source/rat_arf.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module rat_arf (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   instr_valid,
    input  wire ooo_pkg::fu_op_t        instr_op,
    input  wire logic [`OOO_REG_W-1:0]  instr_rd,
    input  wire logic [`OOO_REG_W-1:0]  instr_rs1,
    input  wire logic [`OOO_REG_W-1:0]  instr_rs2,
    input  wire logic [`OOO_XLEN-1:0]   instr_imm,
    output logic                        stall,
    input  wire logic [`OOO_TAG_W-1:0]  rob_tail,
    input  wire logic                   rob_afull,
    input  wire logic                   alu_afull,
    input  wire logic                   mul_afull,
    output logic [`OOO_TAG_W-1:0]       look1_tag,
    output logic [`OOO_TAG_W-1:0]       look2_tag,
    input  wire logic                   look1_done,
    input  wire logic [`OOO_XLEN-1:0]   look1_val,
    input  wire logic                   look2_done,
    input  wire logic [`OOO_XLEN-1:0]   look2_val,
    input  wire logic                   cdb_valid,
    input  wire logic [`OOO_TAG_W-1:0]  cdb_tag,
    input  wire logic [`OOO_XLEN-1:0]   cdb_data,
    input  wire logic                   commit_valid,
    input  wire logic [`OOO_REG_W-1:0]  commit_rd,
    input  wire logic [`OOO_XLEN-1:0]   commit_data,
    input  wire logic [`OOO_TAG_W-1:0]  commit_tag,
    output logic                        disp_any,
    output logic                        disp_alu_valid,
    output logic                        disp_mul_valid,
    output ooo_pkg::fu_op_t             disp_op,
    output logic [`OOO_REG_W-1:0]       disp_rd,
    output logic [`OOO_TAG_W-1:0]       disp_tag,
    output logic                        src1_rdy,
    output logic [`OOO_XLEN-1:0]        src1_val,
    output logic [`OOO_TAG_W-1:0]       src1_tag,
    output logic                        src2_rdy,
    output logic [`OOO_XLEN-1:0]        src2_val,
    output logic [`OOO_TAG_W-1:0]       src2_tag
);

    // per register: committed value, ready flag, newest producer tag
    logic [`OOO_XLEN-1:0]  reg_data [`OOO_NREGS];
    logic                  reg_rdy  [`OOO_NREGS];
    logic [`OOO_TAG_W-1:0] reg_tag  [`OOO_NREGS];

    logic                  accept;
    logic                  is_mul;
    logic [`OOO_XLEN:0]    res1;
    logic [`OOO_XLEN:0]    res2;

    // {ready, value} for one source register
    function automatic logic [`OOO_XLEN:0] resolve(
        input logic [`OOO_REG_W-1:0] rs,
        input logic                  done,
        input logic [`OOO_XLEN-1:0]  lval
    );
        logic [`OOO_TAG_W-1:0] t;
        t = reg_tag[rs];
        if (reg_rdy[rs]) begin
            resolve = {1'b1, reg_data[rs]};
        end else if (cdb_valid && (cdb_tag == t)) begin
            // broadcast in this very cycle
            resolve = {1'b1, cdb_data};
        end else if (done) begin
            resolve = {1'b1, lval};
        end else if (commit_valid && (commit_tag == t)) begin
            // rob entry already freed, file not yet written
            resolve = {1'b1, commit_data};
        end else begin
            resolve = {1'b0, {`OOO_XLEN{1'b0}}};
        end
    endfunction

    assign is_mul = (instr_op == ooo_pkg::op_mul);
    // afull flags already leave room for the packet in flight
    assign stall  = rob_afull || (is_mul ? mul_afull : alu_afull);
    assign accept = instr_valid && !stall;

    assign look1_tag = reg_tag[instr_rs1];
    assign look2_tag = reg_tag[instr_rs2];

    always_comb begin
        res1 = resolve(instr_rs1, look1_done, look1_val);
        res2 = resolve(instr_rs2, look2_done, look2_val);
        // li: immediate on src1, src2 unused
        if (instr_op == ooo_pkg::op_li) begin
            res1 = {1'b1, instr_imm};
            res2 = {1'b1, {`OOO_XLEN{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_NREGS; i++) begin
                reg_data[i] <= '0;
                reg_rdy[i]  <= 1'b1;
                reg_tag[i]  <= '0;
            end
        end else begin
            // commit only counts if still the newest producer
            if (commit_valid && (commit_rd != '0) && (reg_tag[commit_rd] == commit_tag)) begin
                reg_data[commit_rd] <= commit_data;
                reg_rdy[commit_rd]  <= 1'b1;
            end
            // rename overrides a same-cycle commit
            if (accept && (instr_rd != '0)) begin
                reg_rdy[instr_rd] <= 1'b0;
                reg_tag[instr_rd] <= rob_tail;
            end
        end
    end

    // dispatch packet, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_any       <= 1'b0;
            disp_alu_valid <= 1'b0;
            disp_mul_valid <= 1'b0;
        end else begin
            disp_any       <= accept;
            disp_alu_valid <= accept && !is_mul;
            disp_mul_valid <= accept && is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp_op  <= instr_op;
            disp_rd  <= instr_rd;
            disp_tag <= rob_tail;
            src1_rdy <= res1[`OOO_XLEN];
            src1_val <= res1[`OOO_XLEN-1:0];
            src1_tag <= look1_tag;
            src2_rdy <= res2[`OOO_XLEN];
            src2_val <= res2[`OOO_XLEN-1:0];
            src2_tag <= look2_tag;
        end
    end

endmodule

`default_nettype wire

/* source/rob.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module rob (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   disp_any,
    input  wire logic [`OOO_REG_W-1:0]  disp_rd,
    output logic [`OOO_TAG_W-1:0]       rob_tail,
    output logic                        rob_afull,
    input  wire logic [`OOO_TAG_W-1:0]  look1_tag,
    input  wire logic [`OOO_TAG_W-1:0]  look2_tag,
    output logic                        look1_done,
    output logic [`OOO_XLEN-1:0]        look1_val,
    output logic                        look2_done,
    output logic [`OOO_XLEN-1:0]        look2_val,
    input  wire logic                   cdb_valid,
    input  wire logic [`OOO_TAG_W-1:0]  cdb_tag,
    input  wire logic [`OOO_XLEN-1:0]   cdb_data,
    output logic                        commit_valid,
    output logic [`OOO_REG_W-1:0]       commit_rd,
    output logic [`OOO_XLEN-1:0]        commit_data,
    output logic [`OOO_TAG_W-1:0]       commit_tag
);

    ooo_pkg::ent_state_t   state [`OOO_ROB_DEPTH];
    logic [`OOO_REG_W-1:0] ent_rd  [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0]  ent_val [`OOO_ROB_DEPTH];

    logic [`OOO_TAG_W-1:0] head;
    logic [`OOO_TAG_W-1:0] tail;
    logic [`OOO_TAG_W:0]   count;
    logic                  retire;

    // a packet in flight takes tail this cycle, so rename sees the next one
    assign rob_tail  = disp_any ? tail + 1'b1 : tail;
    assign rob_afull = (count >= `OOO_TAG_W'(`OOO_ROB_DEPTH - 1));
    assign retire    = (state[head] == ooo_pkg::st_done);

    // operand lookups for rename
    assign look1_done = (state[look1_tag] == ooo_pkg::st_done);
    assign look1_val  = ent_val[look1_tag];
    assign look2_done = (state[look2_tag] == ooo_pkg::st_done);
    assign look2_val  = ent_val[look2_tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                state[i] <= ooo_pkg::st_empty;
            end
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            // allocate
            if (disp_any) begin
                state[tail] <= ooo_pkg::st_busy;
                tail        <= tail + 1'b1;
            end
            // result from the bus
            if (cdb_valid) begin
                state[cdb_tag] <= ooo_pkg::st_done;
            end
            // in-order retire, one per cycle
            if (retire) begin
                state[head]  <= ooo_pkg::st_empty;
                head         <= head + 1'b1;
                commit_valid <= 1'b1;
            end
            count <= count + (`OOO_TAG_W+1)'(disp_any) - (`OOO_TAG_W+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (disp_any) begin
            ent_rd[tail] <= disp_rd;
        end
        if (cdb_valid) begin
            ent_val[cdb_tag] <= cdb_data;
        end
        if (retire) begin
            commit_rd   <= ent_rd[head];
            commit_data <= ent_val[head];
            commit_tag  <= head;
        end
    end

endmodule

`default_nettype wire

/* source/res_station.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module res_station #(
    parameter int DEPTH = `OOO_RS_DEPTH
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   disp_valid,
    input  wire ooo_pkg::fu_op_t        disp_op,
    input  wire logic [`OOO_TAG_W-1:0]  disp_tag,
    input  wire logic                   src1_rdy,
    input  wire logic [`OOO_XLEN-1:0]   src1_val,
    input  wire logic [`OOO_TAG_W-1:0]  src1_tag,
    input  wire logic                   src2_rdy,
    input  wire logic [`OOO_XLEN-1:0]   src2_val,
    input  wire logic [`OOO_TAG_W-1:0]  src2_tag,
    output logic                        rs_afull,
    input  wire logic                   cdb_valid,
    input  wire logic [`OOO_TAG_W-1:0]  cdb_tag,
    input  wire logic [`OOO_XLEN-1:0]   cdb_data,
    input  wire logic                   issue_ready,
    output logic                        issue_valid,
    output ooo_pkg::fu_op_t             issue_op,
    output logic [`OOO_TAG_W-1:0]       issue_tag,
    output logic [`OOO_XLEN-1:0]        issue_a,
    output logic [`OOO_XLEN-1:0]        issue_b
);

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    ooo_pkg::ent_state_t   slot [DEPTH];
    ooo_pkg::fu_op_t       op   [DEPTH];
    logic [`OOO_TAG_W-1:0] tag  [DEPTH];
    logic                  r1   [DEPTH];
    logic [`OOO_XLEN-1:0]  v1   [DEPTH];
    logic [`OOO_TAG_W-1:0] t1   [DEPTH];
    logic                  r2   [DEPTH];
    logic [`OOO_XLEN-1:0]  v2   [DEPTH];
    logic [`OOO_TAG_W-1:0] t2   [DEPTH];
    // older[i][j] set when entry i was loaded before entry j
    logic [DEPTH-1:0]      older [DEPTH];

    logic [DEPTH-1:0]      rdy_vec;
    logic [IW-1:0]         free_idx;
    logic [IW:0]           free_cnt;
    logic [IW-1:0]         sel;
    logic                  any_rdy;
    logic                  blocked;

    always_comb begin
        free_idx = '0;
        free_cnt = '0;
        sel      = '0;
        any_rdy  = 1'b0;
        // lowest empty slot
        for (int i = DEPTH - 1; i >= 0; i--) begin
            rdy_vec[i] = (slot[i] == ooo_pkg::st_busy) && r1[i] && r2[i];
            if (slot[i] == ooo_pkg::st_empty) begin
                free_idx = IW'(i);
                free_cnt = free_cnt + 1'b1;
            end
        end
        // oldest ready: nothing older is also ready
        for (int i = 0; i < DEPTH; i++) begin
            blocked = 1'b0;
            for (int j = 0; j < DEPTH; j++) begin
                if (rdy_vec[j] && older[j][i]) begin
                    blocked = 1'b1;
                end
            end
            if (rdy_vec[i] && !blocked) begin
                sel     = IW'(i);
                any_rdy = 1'b1;
            end
        end
    end

    // registered dispatch means one more may already be on its way
    assign rs_afull    = (free_cnt < 2);
    assign issue_valid = any_rdy && issue_ready;
    assign issue_op    = op[sel];
    assign issue_tag   = tag[sel];
    assign issue_a     = v1[sel];
    assign issue_b     = v2[sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                slot[i] <= ooo_pkg::st_empty;
            end
        end else begin
            // wakeup on matching broadcast
            for (int i = 0; i < DEPTH; i++) begin
                if ((slot[i] == ooo_pkg::st_busy) && cdb_valid) begin
                    if (!r1[i] && (t1[i] == cdb_tag)) begin
                        r1[i] <= 1'b1;
                        v1[i] <= cdb_data;
                    end
                    if (!r2[i] && (t2[i] == cdb_tag)) begin
                        r2[i] <= 1'b1;
                        v2[i] <= cdb_data;
                    end
                end
            end
            if (issue_valid) begin
                slot[sel] <= ooo_pkg::st_empty;
            end
            if (disp_valid) begin
                slot[free_idx] <= ooo_pkg::st_busy;
                op[free_idx]   <= disp_op;
                tag[free_idx]  <= disp_tag;
                t1[free_idx]   <= src1_tag;
                t2[free_idx]   <= src2_tag;
                // also catch a broadcast during the dispatch cycle
                r1[free_idx] <= src1_rdy || (cdb_valid && (cdb_tag == src1_tag));
                v1[free_idx] <= src1_rdy ? src1_val : cdb_data;
                r2[free_idx] <= src2_rdy || (cdb_valid && (cdb_tag == src2_tag));
                v2[free_idx] <= src2_rdy ? src2_val : cdb_data;
                // every entry already held is older than the new one
                for (int j = 0; j < DEPTH; j++) begin
                    older[free_idx][j] <= 1'b0;
                    older[j][free_idx] <= (slot[j] == ooo_pkg::st_busy);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/func_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module func_unit #(
    parameter int LATENCY = 1
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   issue_valid,
    input  wire ooo_pkg::fu_op_t        issue_op,
    input  wire logic [`OOO_TAG_W-1:0]  issue_tag,
    input  wire logic [`OOO_XLEN-1:0]   issue_a,
    input  wire logic [`OOO_XLEN-1:0]   issue_b,
    output logic                        issue_ready,
    output logic                        res_valid,
    output logic [`OOO_TAG_W-1:0]       res_tag,
    output logic [`OOO_XLEN-1:0]        res_data,
    input  wire logic                   grant
);

    logic [LATENCY-1:0]    stg_v;
    logic [`OOO_TAG_W-1:0] stg_t [LATENCY];
    logic [`OOO_XLEN-1:0]  stg_d [LATENCY];
    logic [`OOO_XLEN-1:0]  result;
    logic                  hold;

    // result waiting for the bus freezes everything behind it
    assign hold        = stg_v[LATENCY-1] && !grant;
    assign issue_ready = !hold;

    always_comb begin
        case (issue_op)
            ooo_pkg::op_add: result = issue_a + issue_b;
            ooo_pkg::op_sub: result = issue_a - issue_b;
            ooo_pkg::op_xor: result = issue_a ^ issue_b;
            ooo_pkg::op_li:  result = issue_a;
            // low half of the product
            ooo_pkg::op_mul: result = issue_a * issue_b;
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stg_v <= '0;
        end else if (!hold) begin
            stg_v[0] <= issue_valid;
            for (int i = 1; i < LATENCY; i++) begin
                stg_v[i] <= stg_v[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            stg_t[0] <= issue_tag;
            stg_d[0] <= result;
            for (int i = 1; i < LATENCY; i++) begin
                stg_t[i] <= stg_t[i-1];
                stg_d[i] <= stg_d[i-1];
            end
        end
    end

    assign res_valid = stg_v[LATENCY-1];
    assign res_tag   = stg_t[LATENCY-1];
    assign res_data  = stg_d[LATENCY-1];

endmodule

`default_nettype wire

/* source/cdb_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module cdb_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   alu_valid,
    input  wire logic [`OOO_TAG_W-1:0]  alu_tag,
    input  wire logic [`OOO_XLEN-1:0]   alu_data,
    input  wire logic                   mul_valid,
    input  wire logic [`OOO_TAG_W-1:0]  mul_tag,
    input  wire logic [`OOO_XLEN-1:0]   mul_data,
    output logic                        alu_grant,
    output logic                        mul_grant,
    output logic                        cdb_valid,
    output logic [`OOO_TAG_W-1:0]       cdb_tag,
    output logic [`OOO_XLEN-1:0]        cdb_data
);

    // high when the multiplier was the last unit granted the bus
    logic last_mul;

    // alu wins when alone or when the multiplier had the last turn
    assign alu_grant = alu_valid && (!mul_valid || last_mul);
    assign mul_grant = mul_valid && !alu_grant;

    assign cdb_valid = alu_valid || mul_valid;
    assign cdb_tag   = alu_grant ? alu_tag : mul_tag;
    assign cdb_data  = alu_grant ? alu_data : mul_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul <= 1'b0;
        end else if (alu_grant) begin
            last_mul <= 1'b0;
        end else if (mul_grant) begin
            last_mul <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/ooo_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_core (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   instr_valid,
    input  wire ooo_pkg::fu_op_t        instr_op,
    input  wire logic [`OOO_REG_W-1:0]  instr_rd,
    input  wire logic [`OOO_REG_W-1:0]  instr_rs1,
    input  wire logic [`OOO_REG_W-1:0]  instr_rs2,
    input  wire logic [`OOO_XLEN-1:0]   instr_imm,
    output logic                        stall,
    output logic                        commit_valid,
    output logic [`OOO_REG_W-1:0]       commit_rd,
    output logic [`OOO_XLEN-1:0]        commit_data
);

    // rename to rob
    logic [`OOO_TAG_W-1:0] rob_tail;
    logic                  rob_afull;
    logic [`OOO_TAG_W-1:0] look1_tag;
    logic [`OOO_TAG_W-1:0] look2_tag;
    logic                  look1_done;
    logic [`OOO_XLEN-1:0]  look1_val;
    logic                  look2_done;
    logic [`OOO_XLEN-1:0]  look2_val;
    logic [`OOO_TAG_W-1:0] commit_tag;

    // dispatch packet
    logic                  disp_any;
    logic                  disp_alu_valid;
    logic                  disp_mul_valid;
    ooo_pkg::fu_op_t       disp_op;
    logic [`OOO_REG_W-1:0] disp_rd;
    logic [`OOO_TAG_W-1:0] disp_tag;
    logic                  src1_rdy;
    logic [`OOO_XLEN-1:0]  src1_val;
    logic [`OOO_TAG_W-1:0] src1_tag;
    logic                  src2_rdy;
    logic [`OOO_XLEN-1:0]  src2_val;
    logic [`OOO_TAG_W-1:0] src2_tag;
    logic                  alu_afull;
    logic                  mul_afull;

    // station to unit
    logic                  alu_iss_ready;
    logic                  alu_iss_valid;
    ooo_pkg::fu_op_t       alu_iss_op;
    logic [`OOO_TAG_W-1:0] alu_iss_tag;
    logic [`OOO_XLEN-1:0]  alu_iss_a;
    logic [`OOO_XLEN-1:0]  alu_iss_b;
    logic                  mul_iss_ready;
    logic                  mul_iss_valid;
    ooo_pkg::fu_op_t       mul_iss_op;
    logic [`OOO_TAG_W-1:0] mul_iss_tag;
    logic [`OOO_XLEN-1:0]  mul_iss_a;
    logic [`OOO_XLEN-1:0]  mul_iss_b;

    // unit results and the shared bus
    logic                  alu_res_valid;
    logic [`OOO_TAG_W-1:0] alu_res_tag;
    logic [`OOO_XLEN-1:0]  alu_res_data;
    logic                  mul_res_valid;
    logic [`OOO_TAG_W-1:0] mul_res_tag;
    logic [`OOO_XLEN-1:0]  mul_res_data;
    logic                  alu_grant;
    logic                  mul_grant;
    logic                  cdb_valid;
    logic [`OOO_TAG_W-1:0] cdb_tag;
    logic [`OOO_XLEN-1:0]  cdb_data;

    rat_arf i_rat_arf (
        .clk, .rst,
        .instr_valid, .instr_op, .instr_rd, .instr_rs1, .instr_rs2, .instr_imm,
        .stall, .rob_tail, .rob_afull, .alu_afull, .mul_afull,
        .look1_tag, .look2_tag, .look1_done, .look1_val, .look2_done, .look2_val,
        .cdb_valid, .cdb_tag, .cdb_data,
        .commit_valid, .commit_rd, .commit_data, .commit_tag,
        .disp_any, .disp_alu_valid, .disp_mul_valid, .disp_op, .disp_rd, .disp_tag,
        .src1_rdy, .src1_val, .src1_tag, .src2_rdy, .src2_val, .src2_tag
    );

    rob i_rob (
        .clk, .rst, .disp_any, .disp_rd, .rob_tail, .rob_afull,
        .look1_tag, .look2_tag, .look1_done, .look1_val, .look2_done, .look2_val,
        .cdb_valid, .cdb_tag, .cdb_data,
        .commit_valid, .commit_rd, .commit_data, .commit_tag
    );

    res_station #(.DEPTH(`OOO_RS_DEPTH)) alu_rs (
        .clk, .rst, .disp_valid(disp_alu_valid), .disp_op, .disp_tag,
        .src1_rdy, .src1_val, .src1_tag, .src2_rdy, .src2_val, .src2_tag,
        .rs_afull(alu_afull), .cdb_valid, .cdb_tag, .cdb_data,
        .issue_ready(alu_iss_ready), .issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
        .issue_tag(alu_iss_tag), .issue_a(alu_iss_a), .issue_b(alu_iss_b)
    );

    res_station #(.DEPTH(`OOO_RS_DEPTH)) mul_rs (
        .clk, .rst, .disp_valid(disp_mul_valid), .disp_op, .disp_tag,
        .src1_rdy, .src1_val, .src1_tag, .src2_rdy, .src2_val, .src2_tag,
        .rs_afull(mul_afull), .cdb_valid, .cdb_tag, .cdb_data,
        .issue_ready(mul_iss_ready), .issue_valid(mul_iss_valid), .issue_op(mul_iss_op),
        .issue_tag(mul_iss_tag), .issue_a(mul_iss_a), .issue_b(mul_iss_b)
    );

    func_unit #(.LATENCY(1)) alu_fu (
        .clk, .rst, .issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
        .issue_tag(alu_iss_tag), .issue_a(alu_iss_a), .issue_b(alu_iss_b),
        .issue_ready(alu_iss_ready), .res_valid(alu_res_valid), .res_tag(alu_res_tag),
        .res_data(alu_res_data), .grant(alu_grant)
    );

    func_unit #(.LATENCY(`OOO_MUL_LATENCY)) mul_fu (
        .clk, .rst, .issue_valid(mul_iss_valid), .issue_op(mul_iss_op),
        .issue_tag(mul_iss_tag), .issue_a(mul_iss_a), .issue_b(mul_iss_b),
        .issue_ready(mul_iss_ready), .res_valid(mul_res_valid), .res_tag(mul_res_tag),
        .res_data(mul_res_data), .grant(mul_grant)
    );

    cdb_arbiter i_cdb_arbiter (
        .clk, .rst,
        .alu_valid(alu_res_valid), .alu_tag(alu_res_tag), .alu_data(alu_res_data),
        .mul_valid(mul_res_valid), .mul_tag(mul_res_tag), .mul_data(mul_res_data),
        .alu_grant, .mul_grant, .cdb_valid, .cdb_tag, .cdb_data
    );

endmodule

`default_nettype wire

/* test/ooo_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_tb;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    ooo_pkg::fu_op_t       instr_op;
    logic [`OOO_REG_W-1:0] instr_rd;
    logic [`OOO_REG_W-1:0] instr_rs1;
    logic [`OOO_REG_W-1:0] instr_rs2;
    logic [`OOO_XLEN-1:0]  instr_imm;
    logic                  stall;
    logic                  commit_valid;
    logic [`OOO_REG_W-1:0] commit_rd;
    logic [`OOO_XLEN-1:0]  commit_data;

    // in-order reference model and its expected commit stream
    logic [`OOO_XLEN-1:0]  model_regs [`OOO_NREGS];
    logic [`OOO_REG_W-1:0] exp_rd_q [$];
    logic [`OOO_XLEN-1:0]  exp_data_q [$];
    logic [`OOO_REG_W-1:0] want_rd;
    logic [`OOO_XLEN-1:0]  want_data;

    string  test_name;
    integer seed;
    int     errors;
    int     accept_cnt;
    int     commit_cnt;
    int     wd_left;
    logic   check_idle;
    logic   saw_stall;

    ooo_core i_ooo_core (
        .clk, .rst, .instr_valid, .instr_op, .instr_rd, .instr_rs1, .instr_rs2,
        .instr_imm, .stall, .commit_valid, .commit_rd, .commit_data
    );

    // 8 ns period
    always #4 clk = ~clk;

    // outputs are sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (check_idle) begin
            assert (!stall && !commit_valid) else begin
                errors++;
                $display("stall or commit_valid went high with no input in test %s", test_name);
            end
        end
        if (commit_valid) begin
            commit_cnt++;
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("commit arrived with nothing outstanding in test %s", test_name);
            end else begin
                want_rd   = exp_rd_q.pop_front();
                want_data = exp_data_q.pop_front();
                assert (commit_rd == want_rd) else begin
                    errors++;
                    $display("[ERROR] %s: commit_rd expected %0d actual %0d",
                             test_name, want_rd, commit_rd);
                end
                assert (commit_data == want_data) else begin
                    errors++;
                    $display("[ERROR] %s: commit_data expected %h actual %h",
                             test_name, want_data, commit_data);
                end
            end
        end
    end

    // per-test watchdog, armed with a cycle budget
    always @(posedge clk) begin
        if (wd_left > 0) begin
            wd_left = wd_left - 1;
            if (wd_left == 0) begin
                $display("watchdog expired, test %s hung with %0d commits outstanding",
                         test_name, exp_rd_q.size());
                $display("Checks failed");
                $finish;
            end
        end
    end

    // result by the instruction rules
    function automatic logic [`OOO_XLEN-1:0] expect_result(
        input ooo_pkg::fu_op_t      op,
        input logic [`OOO_XLEN-1:0] a,
        input logic [`OOO_XLEN-1:0] b,
        input logic [`OOO_XLEN-1:0] imm
    );
        case (op)
            ooo_pkg::op_add: expect_result = a + b;
            ooo_pkg::op_sub: expect_result = a - b;
            ooo_pkg::op_xor: expect_result = a ^ b;
            ooo_pkg::op_li:  expect_result = imm;
            default:         expect_result = a * b;
        endcase
    endfunction

    // mostly low registers so random code has real dependencies
    function automatic logic [`OOO_REG_W-1:0] pick_reg();
        if (($random(seed) & 3) != 0) begin
            pick_reg = `OOO_REG_W'($unsigned($random(seed)) % 8);
        end else begin
            pick_reg = `OOO_REG_W'($unsigned($random(seed)) % `OOO_NREGS);
        end
    endfunction

    task automatic arm_watchdog(input int n_instr);
        wd_left = n_instr * (`OOO_MUL_LATENCY + 20);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // holds the instruction until an edge accepts it, then updates the model
    task automatic send(
        input ooo_pkg::fu_op_t       op,
        input logic [`OOO_REG_W-1:0] rd,
        input logic [`OOO_REG_W-1:0] rs1,
        input logic [`OOO_REG_W-1:0] rs2,
        input logic [`OOO_XLEN-1:0]  imm
    );
        logic                 ok;
        logic [`OOO_XLEN-1:0] val;
        instr_valid = 1'b1;
        instr_op    = op;
        instr_rd    = rd;
        instr_rs1   = rs1;
        instr_rs2   = rs2;
        instr_imm   = imm;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = !stall;
            if (!ok) begin
                saw_stall = 1'b1;
            end
            @(posedge clk);
        end
        val = expect_result(op, model_regs[rs1], model_regs[rs2], imm);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(val);
        // x0 stays zero for readers
        if (rd != '0) begin
            model_regs[rd] = val;
        end
        accept_cnt++;
        #1;
        instr_valid = 1'b0;
    endtask

    // wait for every accepted instruction to commit
    task automatic drain();
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        // a duplicate commit would show up within one more pass through the buffer
        idle(`OOO_ROB_DEPTH + `OOO_MUL_LATENCY);
        assert (commit_cnt == accept_cnt) else begin
            errors++;
            $display("[ERROR] %s: commit count expected %0d actual %0d",
                     test_name, accept_cnt, commit_cnt);
        end
        wd_left = 0;
    endtask

    task automatic run_random(input int n);
        ooo_pkg::fu_op_t op;
        for (int i = 0; i < n; i++) begin
            op = ooo_pkg::fu_op_t'(3'($unsigned($random(seed)) % 5));
            send(op, pick_reg(), pick_reg(), pick_reg(), $random(seed));
            // occasional valid gaps
            if (($random(seed) & 3) == 0) begin
                idle(1 + ($unsigned($random(seed)) % 3));
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_op    = ooo_pkg::op_add;
        instr_rd    = '0;
        instr_rs1   = '0;
        instr_rs2   = '0;
        instr_imm   = '0;
        seed        = 32'h7ad354b3;
        errors      = 0;
        accept_cnt  = 0;
        commit_cnt  = 0;
        wd_left     = 0;
        check_idle  = 1'b0;
        saw_stall   = 1'b0;
        test_name   = "reset_idle";
        for (int i = 0; i < `OOO_NREGS; i++) begin
            model_regs[i] = '0;
        end

        // idle checks start once the first reset edge has landed
        @(posedge clk);
        check_idle = 1'b1;
        repeat (15) @(posedge clk);
        #1;
        rst = 1'b0;

        arm_watchdog(2);
        idle(6);
        check_idle = 1'b0;
        send(ooo_pkg::op_li, 5'd1, 5'd0, 5'd0, 32'h0000_1234);
        drain();

        // dependent chain through x2..x5
        test_name = "dep_chain";
        arm_watchdog(8);
        send(ooo_pkg::op_li, 5'd2, 5'd0, 5'd0, 32'd5);
        send(ooo_pkg::op_li, 5'd3, 5'd0, 5'd0, 32'd7);
        send(ooo_pkg::op_add, 5'd4, 5'd2, 5'd3, '0);
        send(ooo_pkg::op_sub, 5'd4, 5'd4, 5'd2, '0);
        send(ooo_pkg::op_xor, 5'd4, 5'd4, 5'd3, '0);
        send(ooo_pkg::op_add, 5'd2, 5'd4, 5'd4, '0);
        send(ooo_pkg::op_sub, 5'd5, 5'd2, 5'd4, '0);
        send(ooo_pkg::op_xor, 5'd5, 5'd5, 5'd1, '0);
        drain();

        // alu results overtake the multiplier on the bus
        test_name = "mul_mix";
        arm_watchdog(8);
        send(ooo_pkg::op_li, 5'd6, 5'd0, 5'd0, 32'd3);
        send(ooo_pkg::op_li, 5'd7, 5'd0, 5'd0, 32'h0001_0011);
        send(ooo_pkg::op_mul, 5'd8, 5'd6, 5'd7, '0);
        send(ooo_pkg::op_add, 5'd9, 5'd6, 5'd6, '0);
        send(ooo_pkg::op_xor, 5'd10, 5'd7, 5'd6, '0);
        send(ooo_pkg::op_mul, 5'd11, 5'd8, 5'd7, '0);
        send(ooo_pkg::op_sub, 5'd12, 5'd9, 5'd10, '0);
        send(ooo_pkg::op_add, 5'd13, 5'd11, 5'd8, '0);
        drain();

        // serial mul chain fills the station and the buffer
        test_name = "mul_burst";
        arm_watchdog(14);
        saw_stall = 1'b0;
        send(ooo_pkg::op_li, 5'd14, 5'd0, 5'd0, 32'd3);
        for (int i = 0; i < 13; i++) begin
            send(ooo_pkg::op_mul, 5'd14, 5'd14, 5'd7, '0);
        end
        drain();
        assert (saw_stall) else begin
            errors++;
            $display("stall never rose during the mul burst in test %s", test_name);
        end

        // x0 writes and two in-flight writes to x16
        test_name = "x0_rename";
        arm_watchdog(7);
        send(ooo_pkg::op_li, 5'd0, 5'd0, 5'd0, 32'd99);
        send(ooo_pkg::op_add, 5'd15, 5'd0, 5'd0, '0);
        send(ooo_pkg::op_li, 5'd16, 5'd0, 5'd0, 32'd1);
        send(ooo_pkg::op_li, 5'd16, 5'd0, 5'd0, 32'd2);
        send(ooo_pkg::op_add, 5'd17, 5'd16, 5'd0, '0);
        send(ooo_pkg::op_mul, 5'd0, 5'd16, 5'd16, '0);
        send(ooo_pkg::op_add, 5'd18, 5'd0, 5'd16, '0);
        drain();

        test_name = "random_mix";
        arm_watchdog(300);
        run_random(300);
        drain();

        $display("errors: %0d  commits: %0d  accepted: %0d", errors, commit_cnt, accept_cnt);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/ooo_pkg.sv
source/rat_arf.sv
source/rob.sv
source/res_station.sv
source/func_unit.sv
source/cdb_arbiter.sv
source/ooo_core.sv
test/ooo_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ooo_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f src.f --top-module ooo_tb -o ooo_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/ooo_sim 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
